//--- Bender.yml
package:
  name: mem_net

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mem_net_pkg.sv
      - verilog/net_chan_if.sv
      - verilog/net_inject_decode.sv
      - verilog/ring_router.sv
      - verilog/net_eject_result.sv
      - verilog/mem_net_ring.sv
      - verilog/mem_net_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/mem_net_tb.sv

//--- bench/mem_net_tb.sv
// testbench for the two port memory network
// processor and bank models, reference routing, per pair ordered checks
`default_nettype none
`include "mem_net_macros.svh"

module mem_net_tb;
	import mem_net_pkg::*;

	localparam int N_BANKED = 100;
	localparam int N_SINGLE = 40;
	localparam int N_STRESS = 60;
	// requests plus their responses on both ports
	localparam int N_MSGS = 2 * `MN_NUM_PORTS * (N_BANKED + N_SINGLE + N_STRESS);
	localparam int TIMEOUT_CYCLES = 40 * N_MSGS + 2000;

	typedef struct packed {
		mem_req_ctrl_t            ctrl;
		logic [`MN_DATA_BITS-1:0] data;
		logic                     domain;
	} req_rec_t;

	typedef struct packed {
		mem_resp_ctrl_t           ctrl;
		logic [`MN_DATA_BITS-1:0] data;
		logic                     domain;
	} resp_rec_t;

	logic clk;
	logic reset;
	logic mode;

	mem_req_ctrl_t            req_in_ctrl    [2];
	logic [`MN_DATA_BITS-1:0] req_in_data    [2];
	logic                     req_in_domain  [2];
	logic                     req_in_val     [2];
	logic                     req_in_rdy     [2];
	mem_req_ctrl_t            req_out_ctrl   [2];
	logic [`MN_DATA_BITS-1:0] req_out_data   [2];
	logic                     req_out_domain [2];
	logic                     req_out_val    [2];
	logic                     req_out_rdy    [2];
	mem_resp_ctrl_t           resp_in_ctrl   [2];
	logic [`MN_DATA_BITS-1:0] resp_in_data   [2];
	logic                     resp_in_domain [2];
	logic                     resp_in_val    [2];
	logic                     resp_in_rdy    [2];
	mem_resp_ctrl_t           resp_out_ctrl  [2];
	logic [`MN_DATA_BITS-1:0] resp_out_data  [2];
	logic                     resp_out_domain[2];
	logic                     resp_out_val   [2];
	logic                     resp_out_rdy   [2];

	// expected traffic per source and destination
	req_rec_t  req_exp  [2][2][$];
	resp_rec_t resp_exp [2][2][$];
	// responses each bank still has to send
	resp_rec_t bank_q   [2][$];

	logic [31:0] lcg_state;
	bit          stress;
	bit          req_done [2];
	int          to_send  [2];
	int          phase_cycle;
	int          outstanding;
	int          cycles = 0;

	mem_net_top DUT (
		.clk                (clk),
		.reset              (reset),
		.mode               (mode),
		.req_in_msg_p0      ({req_in_ctrl[0], req_in_data[0]}),
		.req_in_val_p0      (req_in_val[0]),
		.req_in_rdy_p0      (req_in_rdy[0]),
		.req_in_domain_p0   (req_in_domain[0]),
		.req_out_ctrl_p0    (req_out_ctrl[0]),
		.req_out_data_p0    (req_out_data[0]),
		.req_out_domain_p0  (req_out_domain[0]),
		.req_out_val_p0     (req_out_val[0]),
		.req_out_rdy_p0     (req_out_rdy[0]),
		.resp_in_ctrl_p0    (resp_in_ctrl[0]),
		.resp_in_data_p0    (resp_in_data[0]),
		.resp_in_domain_p0  (resp_in_domain[0]),
		.resp_in_val_p0     (resp_in_val[0]),
		.resp_in_rdy_p0     (resp_in_rdy[0]),
		.resp_out_ctrl_p0   (resp_out_ctrl[0]),
		.resp_out_data_p0   (resp_out_data[0]),
		.resp_out_domain_p0 (resp_out_domain[0]),
		.resp_out_val_p0    (resp_out_val[0]),
		.resp_out_rdy_p0    (resp_out_rdy[0]),
		.req_in_msg_p1      ({req_in_ctrl[1], req_in_data[1]}),
		.req_in_val_p1      (req_in_val[1]),
		.req_in_rdy_p1      (req_in_rdy[1]),
		.req_in_domain_p1   (req_in_domain[1]),
		.req_out_ctrl_p1    (req_out_ctrl[1]),
		.req_out_data_p1    (req_out_data[1]),
		.req_out_domain_p1  (req_out_domain[1]),
		.req_out_val_p1     (req_out_val[1]),
		.req_out_rdy_p1     (req_out_rdy[1]),
		.resp_in_ctrl_p1    (resp_in_ctrl[1]),
		.resp_in_data_p1    (resp_in_data[1]),
		.resp_in_domain_p1  (resp_in_domain[1]),
		.resp_in_val_p1     (resp_in_val[1]),
		.resp_in_rdy_p1     (resp_in_rdy[1]),
		.resp_out_ctrl_p1   (resp_out_ctrl[1]),
		.resp_out_data_p1   (resp_out_data[1]),
		.resp_out_domain_p1 (resp_out_domain[1]),
		.resp_out_val_p1    (resp_out_val[1]),
		.resp_out_rdy_p1    (resp_out_rdy[1])
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ====================
	// helpers

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// fold the better upper bits down
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	function automatic port_id_t expected_dest(input bit is_req, input logic mode_sel,
		input logic [`MN_ADDR_BITS-1:0] addr, input logic [`MN_OPQ_BITS-1:0] opaque);
		if (!is_req) begin
			return port_id_t'(opaque[`MN_OPQ_BITS-1]);
		end
		if (mode_sel) begin
			return port_id_t'(0);
		end
		return port_id_t'(addr[`MN_BANK_BIT]);
	endfunction

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_req(input int p, input mem_req_ctrl_t got_ctrl,
		input mem_req_ctrl_t exp_ctrl, input logic [`MN_DATA_BITS-1:0] got_data,
		input logic [`MN_DATA_BITS-1:0] exp_data, input logic got_dom, input logic exp_dom);
		if (got_ctrl !== exp_ctrl) begin
			stop_with_error($sformatf("FAILED req_out_ctrl_p%0d: got %h expected %h",
				p, got_ctrl, exp_ctrl));
		end else if (got_data !== exp_data) begin
			stop_with_error($sformatf("FAILED req_out_data_p%0d: got %h expected %h",
				p, got_data, exp_data));
		end else if (got_dom !== exp_dom) begin
			stop_with_error($sformatf("FAILED req_out_domain_p%0d: got %h expected %h",
				p, got_dom, exp_dom));
		end
	endtask

	task automatic check_resp(input int p, input mem_resp_ctrl_t got_ctrl,
		input mem_resp_ctrl_t exp_ctrl, input logic [`MN_DATA_BITS-1:0] got_data,
		input logic [`MN_DATA_BITS-1:0] exp_data, input logic got_dom, input logic exp_dom);
		if (got_ctrl !== exp_ctrl) begin
			stop_with_error($sformatf("FAILED resp_out_ctrl_p%0d: got %h expected %h",
				p, got_ctrl, exp_ctrl));
		end else if (got_data !== exp_data) begin
			stop_with_error($sformatf("FAILED resp_out_data_p%0d: got %h expected %h",
				p, got_data, exp_data));
		end else if (got_dom !== exp_dom) begin
			stop_with_error($sformatf("FAILED resp_out_domain_p%0d: got %h expected %h",
				p, got_dom, exp_dom));
		end
	endtask

	// ====================
	// processor and bank drivers for the falling edge

	task automatic make_request(input int p);
		mem_req_ctrl_t c;
		logic [31:0]   r;
		r = lcg_next();
		c.msg_type = mem_type_e'(3'(r[17:16] % 2'd3));
		// requester id in the opaque msb routes the response home
		c.opaque = {1'(p), r[6:0]};
		c.addr = lcg_next();
		req_in_ctrl[p] = c;
		req_in_data[p] = lcg_next();
		req_in_domain[p] = r[20];
		req_in_val[p] = 1'b1;
		to_send[p]--;
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		for (int p = 0; p < 2; p++) begin
			if (req_done[p]) begin
				req_in_val[p] = 1'b0;
				req_done[p] = 1'b0;
			end
			if (!req_in_val[p] && to_send[p] != 0) begin
				r = lcg_next();
				if (r[9:8] != 2'b00) begin
					make_request(p);
				end
			end
		end
		for (int b = 0; b < 2; b++) begin
			resp_in_val[b] = (bank_q[b].size() != 0);
			if (resp_in_val[b]) begin
				resp_in_ctrl[b] = bank_q[b][0].ctrl;
				resp_in_data[b] = bank_q[b][0].data;
				resp_in_domain[b] = bank_q[b][0].domain;
			end
			req_out_rdy[b] = 1'b1;
			resp_out_rdy[b] = 1'b1;
			if (stress) begin
				r = lcg_next();
				req_out_rdy[b] = r[12] | r[13];
				resp_out_rdy[b] = r[14] | r[15];
			end
		end
		// bank 1 stalls completely for 50 cycles
		if (stress && phase_cycle >= 20 && phase_cycle < 70) begin
			req_out_rdy[1] = 1'b0;
		end
		phase_cycle++;
	endtask

	function automatic bit drained();
		return to_send[0] == 0 && to_send[1] == 0 && !req_in_val[0] && !req_in_val[1]
			&& outstanding == 0;
	endfunction

	task automatic check_idle_state();
		for (int p = 0; p < 2; p++) begin
			check_flag($sformatf("req_out_val_p%0d", p), req_out_val[p], 1'b0);
			check_flag($sformatf("resp_out_val_p%0d", p), resp_out_val[p], 1'b0);
			check_flag($sformatf("req_in_rdy_p%0d", p), req_in_rdy[p], 1'b1);
			check_flag($sformatf("resp_in_rdy_p%0d", p), resp_in_rdy[p], 1'b1);
		end
	endtask

	task automatic run_phase(input logic m, input bit s, input int n);
		mode = m;
		stress = s;
		phase_cycle = 0;
		for (int p = 0; p < 2; p++) begin
			to_send[p] = n;
		end
		drive_inputs();
		while (!drained()) begin
			@(negedge clk);
			drive_inputs();
		end
		// all credits home and nothing left waiting at an output
		check_idle_state();
	endtask

	// ====================
	// transfers seen at the rising edge

	always @(posedge clk) begin : transfer_monitor
		req_rec_t    req_rec;
		resp_rec_t   resp_rec;
		port_id_t    d;
		port_id_t    src;
		logic [31:0] r;
		if (!reset) begin
			for (int p = 0; p < 2; p++) begin
				if (req_in_val[p] && req_in_rdy[p]) begin
					req_rec = '{ctrl: req_in_ctrl[p], data: req_in_data[p],
						domain: req_in_domain[p]};
					d = expected_dest(1'b1, mode, req_in_ctrl[p].addr, req_in_ctrl[p].opaque);
					req_exp[p][d].push_back(req_rec);
					req_done[p] = 1'b1;
					outstanding++;
				end
				if (resp_in_val[p] && resp_in_rdy[p]) begin
					resp_rec = bank_q[p].pop_front();
					d = expected_dest(1'b0, mode, '0, resp_rec.ctrl.opaque);
					resp_exp[p][d].push_back(resp_rec);
				end
			end
			for (int b = 0; b < 2; b++) begin
				if (req_out_val[b] && req_out_rdy[b]) begin
					src = req_out_ctrl[b].opaque[`MN_OPQ_BITS-1];
					if (req_exp[src][b].size() == 0) begin
						stop_with_error($sformatf(
							"request from port %0d reached bank %0d unexpectedly", src, b));
					end else begin
						req_rec = req_exp[src][b].pop_front();
						check_req(b, req_out_ctrl[b], req_rec.ctrl, req_out_data[b],
							req_rec.data, req_out_domain[b], req_rec.domain);
						// bank answers with its own id in data bit 0
						r = lcg_next();
						resp_rec.ctrl = '{msg_type: req_rec.ctrl.msg_type,
							opaque: req_rec.ctrl.opaque};
						resp_rec.data = {r[31:1], 1'(b)};
						resp_rec.domain = req_rec.domain;
						bank_q[b].push_back(resp_rec);
					end
				end
				if (resp_out_val[b] && resp_out_rdy[b]) begin
					src = resp_out_data[b][0];
					if (resp_exp[src][b].size() == 0) begin
						stop_with_error($sformatf(
							"response at port %0d with none expected from bank %0d", b, src));
					end else begin
						resp_rec = resp_exp[src][b].pop_front();
						check_resp(b, resp_out_ctrl[b], resp_rec.ctrl, resp_out_data[b],
							resp_rec.data, resp_out_domain[b], resp_rec.domain);
						outstanding--;
					end
				end
			end
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_with_error("timeout: traffic did not drain");
		end
	end

	// ====================
	// test sequence

	initial begin : stimulus
		lcg_state = 32'hd2e4;
		reset = 1'b1;
		mode = 1'b0;
		stress = 1'b0;
		phase_cycle = 0;
		outstanding = 0;
		for (int p = 0; p < 2; p++) begin
			req_in_ctrl[p] = '0;
			req_in_data[p] = '0;
			req_in_domain[p] = 1'b0;
			req_in_val[p] = 1'b0;
			req_out_rdy[p] = 1'b0;
			resp_in_ctrl[p] = '0;
			resp_in_data[p] = '0;
			resp_in_domain[p] = 1'b0;
			resp_in_val[p] = 1'b0;
			resp_out_rdy[p] = 1'b0;
			req_done[p] = 1'b0;
			to_send[p] = 0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_idle_state();

		run_phase(1'b0, 1'b0, N_BANKED);
		run_phase(1'b1, 1'b0, N_SINGLE);
		run_phase(1'b0, 1'b1, N_STRESS);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
verilog/mem_net_pkg.sv
verilog/net_chan_if.sv
verilog/net_inject_decode.sv
verilog/ring_router.sv
verilog/net_eject_result.sv
verilog/mem_net_ring.sv
verilog/mem_net_top.sv
bench/mem_net_tb.sv

//--- include/mem_net_macros.svh
// network dimensions, memory message widths, bank select bit
// and receive buffer depth
`ifndef MEM_NET_MACROS_SVH
`define MEM_NET_MACROS_SVH

// ring size, node ids are one bit wide
`define MN_NUM_PORTS 2

// memory message fields
`define MN_OPQ_BITS  8
`define MN_ADDR_BITS 32
`define MN_DATA_BITS 32

// address bit that picks the bank in banked mode
`define MN_BANK_BIT  4

// receive buffer depth, equal to the credits a sender starts with
`define MN_CREDITS   4

`endif

//--- verilog/mem_net_pkg.sv
// shared types of the memory network
// opcodes, request and response control, network header, arbiter state
`default_nettype none
`include "mem_net_macros.svh"

package mem_net_pkg;

	typedef logic [$clog2(`MN_NUM_PORTS)-1:0] port_id_t;

	typedef enum logic [2:0] {
		mem_read       = 3'd0,
		mem_write      = 3'd1,
		mem_write_init = 3'd2
	} mem_type_e;

	// the data word travels beside these fields, not inside them
	typedef struct packed {
		mem_type_e                msg_type;
		logic [`MN_OPQ_BITS-1:0]  opaque;
		logic [`MN_ADDR_BITS-1:0] addr;
	} mem_req_ctrl_t;

	typedef struct packed {
		mem_type_e               msg_type;
		logic [`MN_OPQ_BITS-1:0] opaque;
	} mem_resp_ctrl_t;

	typedef struct packed {
		port_id_t dest;
		port_id_t src;
		logic     domain;
	} net_hdr_t;

	// round robin memory of a ring router
	typedef enum logic {
		prefer_through,
		prefer_inject
	} arb_state_e;

endpackage

`default_nettype wire

//--- verilog/mem_net_ring.sv
// one complete two node ring for a single payload width
// decode, router and result stage per node, six credit links
`default_nettype none
`include "mem_net_macros.svh"

module mem_net_ring #(
	parameter int PAYLOAD_BITS = 8,
	parameter bit IS_REQ       = 1'b1
) (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          mode,
	input  logic [`MN_NUM_PORTS-1:0]                      in_val,
	output logic [`MN_NUM_PORTS-1:0]                      in_rdy,
	input  logic [`MN_NUM_PORTS-1:0][PAYLOAD_BITS-1:0]    in_ctrl,
	input  logic [`MN_NUM_PORTS-1:0][`MN_DATA_BITS-1:0]   in_data,
	input  logic [`MN_NUM_PORTS-1:0]                      in_domain,
	output logic [`MN_NUM_PORTS-1:0]                      out_val,
	input  logic [`MN_NUM_PORTS-1:0]                      out_rdy,
	output logic [`MN_NUM_PORTS-1:0][PAYLOAD_BITS-1:0]    out_ctrl,
	output logic [`MN_NUM_PORTS-1:0][`MN_DATA_BITS-1:0]   out_data,
	output logic [`MN_NUM_PORTS-1:0]                      out_domain
);
	import mem_net_pkg::*;

	net_chan_if #(.PAYLOAD_BITS(PAYLOAD_BITS)) inj_link   [`MN_NUM_PORTS] ();
	net_chan_if #(.PAYLOAD_BITS(PAYLOAD_BITS)) ring_link  [`MN_NUM_PORTS] ();
	net_chan_if #(.PAYLOAD_BITS(PAYLOAD_BITS)) eject_link [`MN_NUM_PORTS] ();

	for (genvar n = 0; n < `MN_NUM_PORTS; n++) begin : g_node
		// ring link n leaves node n, node n takes link n-1
		localparam int PREV = (n + `MN_NUM_PORTS - 1) % `MN_NUM_PORTS;

		net_inject_decode #(.PAYLOAD_BITS(PAYLOAD_BITS), .IS_REQ(IS_REQ)) decode (
			.clk       (clk),
			.reset     (reset),
			.mode      (mode),
			.src_id    (port_id_t'(n)),
			.in_val    (in_val[n]),
			.in_rdy    (in_rdy[n]),
			.in_ctrl   (in_ctrl[n]),
			.in_data   (in_data[n]),
			.in_domain (in_domain[n]),
			.out       (inj_link[n])
		);

		ring_router #(.PAYLOAD_BITS(PAYLOAD_BITS)) router (
			.clk      (clk),
			.reset    (reset),
			.node_id  (port_id_t'(n)),
			.inj      (inj_link[n]),
			.ring_in  (ring_link[PREV]),
			.ring_out (ring_link[n]),
			.eject    (eject_link[n])
		);

		net_eject_result #(.PAYLOAD_BITS(PAYLOAD_BITS)) result (
			.clk        (clk),
			.reset      (reset),
			.in         (eject_link[n]),
			.out_val    (out_val[n]),
			.out_rdy    (out_rdy[n]),
			.out_ctrl   (out_ctrl[n]),
			.out_data   (out_data[n]),
			.out_domain (out_domain[n])
		);
	end

endmodule

`default_nettype wire

//--- verilog/mem_net_top.sv
// memory network top level with request and response rings
// flat val/rdy ports for processor side and bank side of both ports
`default_nettype none
`include "mem_net_macros.svh"

module mem_net_top (
	input  logic                                                   clk,
	input  logic                                                   reset,
	input  logic                                                   mode,

	input  logic [$bits(mem_net_pkg::mem_req_ctrl_t)+`MN_DATA_BITS-1:0] req_in_msg_p0,
	input  logic                                                   req_in_val_p0,
	output logic                                                   req_in_rdy_p0,
	input  logic                                                   req_in_domain_p0,
	output mem_net_pkg::mem_req_ctrl_t                             req_out_ctrl_p0,
	output logic [`MN_DATA_BITS-1:0]                               req_out_data_p0,
	output logic                                                   req_out_domain_p0,
	output logic                                                   req_out_val_p0,
	input  logic                                                   req_out_rdy_p0,
	input  mem_net_pkg::mem_resp_ctrl_t                            resp_in_ctrl_p0,
	input  logic [`MN_DATA_BITS-1:0]                               resp_in_data_p0,
	input  logic                                                   resp_in_domain_p0,
	input  logic                                                   resp_in_val_p0,
	output logic                                                   resp_in_rdy_p0,
	output mem_net_pkg::mem_resp_ctrl_t                            resp_out_ctrl_p0,
	output logic [`MN_DATA_BITS-1:0]                               resp_out_data_p0,
	output logic                                                   resp_out_domain_p0,
	output logic                                                   resp_out_val_p0,
	input  logic                                                   resp_out_rdy_p0,

	input  logic [$bits(mem_net_pkg::mem_req_ctrl_t)+`MN_DATA_BITS-1:0] req_in_msg_p1,
	input  logic                                                   req_in_val_p1,
	output logic                                                   req_in_rdy_p1,
	input  logic                                                   req_in_domain_p1,
	output mem_net_pkg::mem_req_ctrl_t                             req_out_ctrl_p1,
	output logic [`MN_DATA_BITS-1:0]                               req_out_data_p1,
	output logic                                                   req_out_domain_p1,
	output logic                                                   req_out_val_p1,
	input  logic                                                   req_out_rdy_p1,
	input  mem_net_pkg::mem_resp_ctrl_t                            resp_in_ctrl_p1,
	input  logic [`MN_DATA_BITS-1:0]                               resp_in_data_p1,
	input  logic                                                   resp_in_domain_p1,
	input  logic                                                   resp_in_val_p1,
	output logic                                                   resp_in_rdy_p1,
	output mem_net_pkg::mem_resp_ctrl_t                            resp_out_ctrl_p1,
	output logic [`MN_DATA_BITS-1:0]                               resp_out_data_p1,
	output logic                                                   resp_out_domain_p1,
	output logic                                                   resp_out_val_p1,
	input  logic                                                   resp_out_rdy_p1
);
	import mem_net_pkg::*;

	localparam int REQ_BITS  = $bits(mem_req_ctrl_t);
	localparam int RESP_BITS = $bits(mem_resp_ctrl_t);
	localparam int D         = `MN_DATA_BITS;

	// ====================
	// request ring, processor to bank

	mem_net_ring #(.PAYLOAD_BITS(REQ_BITS), .IS_REQ(1'b1)) req_ring (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.in_val     ({req_in_val_p1, req_in_val_p0}),
		.in_rdy     ({req_in_rdy_p1, req_in_rdy_p0}),
		// processor message holds control above the data word
		.in_ctrl    ({req_in_msg_p1[REQ_BITS+D-1:D], req_in_msg_p0[REQ_BITS+D-1:D]}),
		.in_data    ({req_in_msg_p1[D-1:0], req_in_msg_p0[D-1:0]}),
		.in_domain  ({req_in_domain_p1, req_in_domain_p0}),
		.out_val    ({req_out_val_p1, req_out_val_p0}),
		.out_rdy    ({req_out_rdy_p1, req_out_rdy_p0}),
		.out_ctrl   ({req_out_ctrl_p1, req_out_ctrl_p0}),
		.out_data   ({req_out_data_p1, req_out_data_p0}),
		.out_domain ({req_out_domain_p1, req_out_domain_p0})
	);

	// ====================
	// response ring, bank to processor

	mem_net_ring #(.PAYLOAD_BITS(RESP_BITS), .IS_REQ(1'b0)) resp_ring (
		.clk        (clk),
		.reset      (reset),
		.mode       (mode),
		.in_val     ({resp_in_val_p1, resp_in_val_p0}),
		.in_rdy     ({resp_in_rdy_p1, resp_in_rdy_p0}),
		.in_ctrl    ({resp_in_ctrl_p1, resp_in_ctrl_p0}),
		.in_data    ({resp_in_data_p1, resp_in_data_p0}),
		.in_domain  ({resp_in_domain_p1, resp_in_domain_p0}),
		.out_val    ({resp_out_val_p1, resp_out_val_p0}),
		.out_rdy    ({resp_out_rdy_p1, resp_out_rdy_p0}),
		.out_ctrl   ({resp_out_ctrl_p1, resp_out_ctrl_p0}),
		.out_data   ({resp_out_data_p1, resp_out_data_p0}),
		.out_domain ({resp_out_domain_p1, resp_out_domain_p0})
	);

endmodule

`default_nettype wire

//--- verilog/net_chan_if.sv
// credit based link between network stages
// sender and receiver modports
`default_nettype none
`include "mem_net_macros.svh"

interface net_chan_if #(
	parameter int PAYLOAD_BITS = 8
);
	import mem_net_pkg::*;

	logic                     val;
	net_hdr_t                 hdr;
	logic [PAYLOAD_BITS-1:0]  payload;
	logic [`MN_DATA_BITS-1:0] data;
	// one pulse per entry dequeued at the receiver
	logic                     credit;

	modport sender (
		output val,
		output hdr,
		output payload,
		output data,
		input  credit
	);

	modport receiver (
		input  val,
		input  hdr,
		input  payload,
		input  data,
		output credit
	);

endinterface

`default_nettype wire

//--- verilog/net_eject_result.sv
// ejection stage with receive FIFO and credit return
// the FIFO head is presented as a val/rdy memory message
`default_nettype none
`include "mem_net_macros.svh"

module net_eject_result #(
	parameter int PAYLOAD_BITS = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	net_chan_if.receiver             in,
	output logic                     out_val,
	input  logic                     out_rdy,
	output logic [PAYLOAD_BITS-1:0]  out_ctrl,
	output logic [`MN_DATA_BITS-1:0] out_data,
	output logic                     out_domain
);
	localparam int ENT_BITS = 1 + PAYLOAD_BITS + `MN_DATA_BITS;
	localparam int PTR_BITS = $clog2(`MN_CREDITS);
	localparam int CNT_BITS = PTR_BITS + 1;

	logic [ENT_BITS-1:0] mem [`MN_CREDITS];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                deq;

	// routing fields are dropped here, only the domain bit survives
	always_ff @(posedge clk) begin
		if (in.val) begin
			mem[wr_ptr] <= {in.hdr.domain, in.payload, in.data};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_BITS'(in.val);
			rd_ptr <= rd_ptr + PTR_BITS'(deq);
			count  <= count + CNT_BITS'(in.val) - CNT_BITS'(deq);
		end
	end

	assign out_val                          = (count != '0);
	assign {out_domain, out_ctrl, out_data} = mem[rd_ptr];
	assign deq                              = out_val && out_rdy;
	assign in.credit                        = deq;

	// router credits bound the number of flits in flight to this FIFO
	assert property (@(posedge clk) disable iff (reset)
		in.val && count == CNT_BITS'(`MN_CREDITS) |-> deq)
		else $error("ejection FIFO overflow");

endmodule

`default_nettype wire

//--- verilog/net_inject_decode.sv
// injection adapter from val/rdy memory message to routed flit
// destination logic and the injection link credit counter
`default_nettype none
`include "mem_net_macros.svh"

module net_inject_decode #(
	parameter int PAYLOAD_BITS = 8,
	parameter bit IS_REQ       = 1'b1
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     mode,
	input  mem_net_pkg::port_id_t    src_id,
	input  logic                     in_val,
	output logic                     in_rdy,
	input  logic [PAYLOAD_BITS-1:0]  in_ctrl,
	input  logic [`MN_DATA_BITS-1:0] in_data,
	input  logic                     in_domain,
	net_chan_if.sender               out
);
	import mem_net_pkg::*;

	localparam int CNT_BITS = $clog2(`MN_CREDITS) + 1;

	logic [CNT_BITS-1:0] credits;
	logic                xfer;
	port_id_t            dest;

	// ====================
	// routing

	if (IS_REQ) begin : g_req
		mem_req_ctrl_t req_ctrl;

		assign req_ctrl = in_ctrl;
		// single bank mode sends everything to bank 0
		assign dest = mode ? port_id_t'(0) : port_id_t'(req_ctrl.addr[`MN_BANK_BIT]);
	end else begin : g_resp
		mem_resp_ctrl_t resp_ctrl;

		assign resp_ctrl = in_ctrl;
		// requester put its own port in the opaque msb
		assign dest = port_id_t'(resp_ctrl.opaque[`MN_OPQ_BITS-1]);
	end

	// ====================
	// credits

	assign in_rdy = (credits != '0);
	assign xfer   = in_val && in_rdy;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CNT_BITS'(`MN_CREDITS);
		end else begin
			credits <= credits - CNT_BITS'(xfer) + CNT_BITS'(out.credit);
		end
	end

	assign out.val     = xfer;
	assign out.hdr     = '{dest: dest, src: src_id, domain: in_domain};
	assign out.payload = in_ctrl;
	assign out.data    = in_data;

	// the router never returns more credits than flits it was sent
	assert property (@(posedge clk) disable iff (reset)
		credits <= CNT_BITS'(`MN_CREDITS))
		else $error("injection credit counter overflow");

endmodule

`default_nettype wire

//--- verilog/ring_router.sv
// ring node with through and injection buffers and a two way arbiter
// flits eject here or move on, one credit counter per output link
`default_nettype none
`include "mem_net_macros.svh"

module ring_router #(
	parameter int PAYLOAD_BITS = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  mem_net_pkg::port_id_t node_id,
	net_chan_if.receiver          inj,
	net_chan_if.receiver          ring_in,
	net_chan_if.sender            ring_out,
	net_chan_if.sender            eject
);
	import mem_net_pkg::*;

	localparam int HDR_BITS  = $bits(net_hdr_t);
	localparam int FLIT_BITS = HDR_BITS + PAYLOAD_BITS + `MN_DATA_BITS;
	localparam int PTR_BITS  = $clog2(`MN_CREDITS);
	localparam int CNT_BITS  = PTR_BITS + 1;

	// inputs: 0 through traffic, 1 injected traffic
	logic                 in_val   [2];
	logic [FLIT_BITS-1:0] in_flit  [2];
	logic [FLIT_BITS-1:0] head     [2];
	net_hdr_t             head_hdr [2];
	logic [1:0]           can_go;
	logic [1:0]           grant;
	logic [1:0]           tgt;
	logic                 conflict;
	arb_state_e           arb;
	// outputs: 0 eject, 1 ring link
	logic [CNT_BITS-1:0]  cred     [2];
	logic [FLIT_BITS-1:0] out_flit [2];
	logic [1:0]           send;
	logic [1:0]           credit_in;

	assign in_val[0]      = ring_in.val;
	assign in_flit[0]     = {ring_in.hdr, ring_in.payload, ring_in.data};
	assign in_val[1]      = inj.val;
	assign in_flit[1]     = {inj.hdr, inj.payload, inj.data};
	assign ring_in.credit = grant[0];
	assign inj.credit     = grant[1];

	// ====================
	// input buffers

	for (genvar i = 0; i < 2; i++) begin : g_buf
		logic [FLIT_BITS-1:0] mem [`MN_CREDITS];
		logic [PTR_BITS-1:0]  wr_ptr;
		logic [PTR_BITS-1:0]  rd_ptr;
		logic [CNT_BITS-1:0]  count;

		always_ff @(posedge clk) begin
			if (in_val[i]) begin
				mem[wr_ptr] <= in_flit[i];
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end else begin
				wr_ptr <= wr_ptr + PTR_BITS'(in_val[i]);
				rd_ptr <= rd_ptr + PTR_BITS'(grant[i]);
				count  <= count + CNT_BITS'(in_val[i]) - CNT_BITS'(grant[i]);
			end
		end

		// the buffer register is the one cycle of the hop
		assign head[i]     = mem[rd_ptr];
		assign head_hdr[i] = head[i][FLIT_BITS-1 -: HDR_BITS];
		assign tgt[i]      = (head_hdr[i].dest != node_id);
		assign can_go[i]   = (count != '0) && (cred[tgt[i]] != '0);

		// upstream credits must keep this buffer from overflowing
		assert property (@(posedge clk) disable iff (reset)
			in_val[i] && count == CNT_BITS'(`MN_CREDITS) |-> grant[i])
			else $error("router input buffer overflow");
	end

	// ====================
	// arbitration

	assign conflict = can_go[0] && can_go[1] && (tgt[0] == tgt[1]);
	assign grant[0] = can_go[0] && !(conflict && arb == prefer_inject);
	assign grant[1] = can_go[1] && !(conflict && arb == prefer_through);

	// the loser of a conflict wins the next one
	always_ff @(posedge clk) begin
		if (reset) begin
			arb <= prefer_through;
		end else if (conflict) begin
			arb <= grant[0] ? prefer_inject : prefer_through;
		end
	end

	// ====================
	// output links

	assign credit_in[0] = eject.credit;
	assign credit_in[1] = ring_out.credit;

	for (genvar o = 0; o < 2; o++) begin : g_out
		assign send[o] = (grant[0] && tgt[0] == 1'(o)) || (grant[1] && tgt[1] == 1'(o));
		assign out_flit[o] = (grant[1] && tgt[1] == 1'(o)) ? head[1] : head[0];

		always_ff @(posedge clk) begin
			if (reset) begin
				cred[o] <= CNT_BITS'(`MN_CREDITS);
			end else begin
				cred[o] <= cred[o] - CNT_BITS'(send[o]) + CNT_BITS'(credit_in[o]);
			end
		end

		// downstream may only return credits for flits it holds
		assert property (@(posedge clk) disable iff (reset)
			cred[o] <= CNT_BITS'(`MN_CREDITS))
			else $error("router output credit overflow");
	end

	assign eject.val                                       = send[0];
	assign {eject.hdr, eject.payload, eject.data}          = out_flit[0];
	assign ring_out.val                                    = send[1];
	assign {ring_out.hdr, ring_out.payload, ring_out.data} = out_flit[1];

endmodule

`default_nettype wire
